// ==== source/lc3b_isa_pkg.sv ====
package lc3b_isa_pkg;

	localparam int LC3B_WORD_WIDTH = 16;

	typedef logic [LC3B_WORD_WIDTH-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// Encodings 1010 and 1011 are unused in LC-3b.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	function automatic logic opcode_writes_reg(lc3b_opcode op);
		logic writes;
		case (op)
			op_add, op_and, op_not, op_ldr, op_lea, op_ldb: writes = 1'b1;
			default: writes = 1'b0;
		endcase
		return writes;
	endfunction

endpackage

// ==== source/rob_pkg.sv ====
package rob_pkg;

	localparam int ROB_TAG_WIDTH = 3;
	localparam int ROB_DEPTH = 2 ** ROB_TAG_WIDTH;

	// Entry index, also handed out as the instruction tag.
	typedef logic [ROB_TAG_WIDTH-1:0] rob_tag;

	// Written once at dispatch, in program order.
	typedef struct packed {
		lc3b_isa_pkg::lc3b_opcode opcode;
		lc3b_isa_pkg::lc3b_reg    dest;
		logic                     predict;
	} rob_dispatch_t;

	// Written at writeback, by tag.
	typedef struct packed {
		lc3b_isa_pkg::lc3b_word value;
		logic                   taken;
	} rob_result_t;

endpackage

// ==== source/rob_field_array.sv ====
`timescale 1ns/1ps

module rob_field_array #(
	parameter type payload_t = rob_pkg::rob_dispatch_t
) (
	input  logic           clk,
	input  logic           we,
	input  rob_pkg::rob_tag waddr,
	input  payload_t       wdata,
	input  rob_pkg::rob_tag raddr,
	output payload_t       rdata
);

	import rob_pkg::*;

	payload_t mem [ROB_DEPTH];

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// Head read is combinational.
	assign rdata = mem[raddr];

endmodule

// ==== source/rob_control.sv ====
`timescale 1ns/1ps

module rob_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  disp_valid,
	input  logic                  wb_valid,
	input  rob_pkg::rob_tag       wb_tag,
	input  rob_pkg::rob_dispatch_t head_dispatch,
	input  rob_pkg::rob_result_t  head_result,
	input  logic                  retire_ready,
	output logic                  disp_ready,
	output rob_pkg::rob_tag       tail_tag,
	output logic                  disp_we,
	output logic                  wb_we,
	output rob_pkg::rob_tag       head_tag,
	output logic                  pop,
	output logic                  pop_mispredict,
	output logic                  flush
);

	import lc3b_isa_pkg::*;
	import rob_pkg::*;

	rob_tag                 head;
	rob_tag                 tail;
	logic [ROB_TAG_WIDTH:0] count;
	logic [ROB_DEPTH-1:0]   allocated;
	logic [ROB_DEPTH-1:0]   complete;
	logic                   head_mispredict;

	assign head_tag = head;
	assign tail_tag = tail;

	// A branch mispredicts when its resolved direction differs from the guess.
	always_comb
	begin
		head_mispredict = (head_dispatch.opcode == op_br) &&
			(head_result.taken != head_dispatch.predict);
	end

	// Complete implies allocated, so an empty buffer never pops.
	assign pop = complete[head] && retire_ready;
	assign pop_mispredict = pop && head_mispredict;
	assign flush = pop_mispredict;

	assign disp_ready = (count < ROB_DEPTH) && !flush;
	assign disp_we = disp_valid && disp_ready;

	// Writebacks to free entries are dropped.
	assign wb_we = wb_valid && allocated[wb_tag];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			allocated <= '0;
			complete  <= '0;
		end
		else if (flush)
		begin
			// Everything younger than the branch is discarded.
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			allocated <= '0;
			complete  <= '0;
		end
		else
		begin
			if (disp_we)
			begin
				allocated[tail] <= 1'b1;
				complete[tail]  <= 1'b0;
				tail            <= tail + 1'b1;
			end

			if (wb_we)
			begin
				complete[wb_tag] <= 1'b1;
			end

			// Retirement frees the head slot; comes last so it wins over writeback.
			if (pop)
			begin
				allocated[head] <= 1'b0;
				complete[head]  <= 1'b0;
				head            <= head + 1'b1;
			end

			case ({disp_we, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== source/rob_retire_queue.sv ====
`timescale 1ns/1ps

module rob_retire_queue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     push,
	input  rob_pkg::rob_dispatch_t   push_dispatch,
	input  rob_pkg::rob_result_t     push_result,
	input  logic                     push_mispredict,
	input  logic                     cmt_ready,
	output logic                     retire_ready,
	output logic                     cmt_valid,
	output lc3b_isa_pkg::lc3b_opcode cmt_opcode,
	output lc3b_isa_pkg::lc3b_reg    cmt_dest,
	output lc3b_isa_pkg::lc3b_word   cmt_value,
	output logic                     cmt_reg_we,
	output logic                     cmt_mispredict
);

	import lc3b_isa_pkg::*;
	import rob_pkg::*;

	rob_dispatch_t slot_dispatch [2];
	rob_result_t   slot_result [2];
	logic          slot_mispredict [2];
	logic          wr_ptr;
	logic          rd_ptr;
	logic [1:0]    count;
	logic          drain;

	assign retire_ready = (count < 2'd2);
	assign cmt_valid = (count != 2'd0);
	assign drain = cmt_valid && cmt_ready;

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			slot_dispatch[wr_ptr]   <= push_dispatch;
			slot_result[wr_ptr]     <= push_result;
			slot_mispredict[wr_ptr] <= push_mispredict;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= ~wr_ptr;
			end
			if (drain)
			begin
				rd_ptr <= ~rd_ptr;
			end
			case ({push, drain})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

	assign cmt_opcode = slot_dispatch[rd_ptr].opcode;
	assign cmt_dest = slot_dispatch[rd_ptr].dest;
	assign cmt_value = slot_result[rd_ptr].value;
	assign cmt_mispredict = slot_mispredict[rd_ptr];
	assign cmt_reg_we = cmt_valid && opcode_writes_reg(cmt_opcode);

endmodule

// ==== source/rob_top.sv ====
`timescale 1ns/1ps

module rob_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     disp_valid,
	input  lc3b_isa_pkg::lc3b_opcode disp_opcode,
	input  lc3b_isa_pkg::lc3b_reg    disp_dest,
	input  logic                     disp_predict,
	input  logic                     wb_valid,
	input  rob_pkg::rob_tag          wb_tag,
	input  lc3b_isa_pkg::lc3b_word   wb_value,
	input  logic                     wb_taken,
	input  logic                     cmt_ready,
	output logic                     disp_ready,
	output rob_pkg::rob_tag          disp_tag,
	output logic                     cmt_valid,
	output lc3b_isa_pkg::lc3b_opcode cmt_opcode,
	output lc3b_isa_pkg::lc3b_reg    cmt_dest,
	output lc3b_isa_pkg::lc3b_word   cmt_value,
	output logic                     cmt_reg_we,
	output logic                     cmt_mispredict,
	output logic                     flush
);

	import rob_pkg::*;

	rob_dispatch_t disp_payload;
	rob_result_t   wb_payload;
	rob_dispatch_t head_dispatch;
	rob_result_t   head_result;
	rob_tag        tail_tag;
	rob_tag        head_tag;
	logic          disp_we;
	logic          wb_we;
	logic          pop;
	logic          pop_mispredict;
	logic          retire_ready;

	assign disp_payload = '{opcode: disp_opcode, dest: disp_dest, predict: disp_predict};
	assign wb_payload = '{value: wb_value, taken: wb_taken};
	assign disp_tag = tail_tag;

	rob_control control0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.disp_valid     (disp_valid),
		.wb_valid       (wb_valid),
		.wb_tag         (wb_tag),
		.head_dispatch  (head_dispatch),
		.head_result    (head_result),
		.retire_ready   (retire_ready),
		.disp_ready     (disp_ready),
		.tail_tag       (tail_tag),
		.disp_we        (disp_we),
		.wb_we          (wb_we),
		.head_tag       (head_tag),
		.pop            (pop),
		.pop_mispredict (pop_mispredict),
		.flush          (flush)
	);

	rob_field_array #(.payload_t(rob_dispatch_t)) dispatch_store0 (
		.clk   (clk),
		.we    (disp_we),
		.waddr (tail_tag),
		.wdata (disp_payload),
		.raddr (head_tag),
		.rdata (head_dispatch)
	);

	rob_field_array #(.payload_t(rob_result_t)) result_store0 (
		.clk   (clk),
		.we    (wb_we),
		.waddr (wb_tag),
		.wdata (wb_payload),
		.raddr (head_tag),
		.rdata (head_result)
	);

	rob_retire_queue retire_queue0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.push            (pop),
		.push_dispatch   (head_dispatch),
		.push_result     (head_result),
		.push_mispredict (pop_mispredict),
		.cmt_ready       (cmt_ready),
		.retire_ready    (retire_ready),
		.cmt_valid       (cmt_valid),
		.cmt_opcode      (cmt_opcode),
		.cmt_dest        (cmt_dest),
		.cmt_value       (cmt_value),
		.cmt_reg_we      (cmt_reg_we),
		.cmt_mispredict  (cmt_mispredict)
	);

endmodule

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

	import lc3b_isa_pkg::*;
	import rob_pkg::*;

	typedef struct {
		rob_tag     tag;
		lc3b_opcode op;
		lc3b_reg    dest;
		logic       predict;
		lc3b_word   value;
		logic       taken;
		logic       done;
		logic       misp;
	} entry_t;

	logic       clk = 1'b0;
	logic       rst_n, disp_valid, disp_predict, wb_valid, wb_taken, cmt_ready;
	logic       disp_ready, cmt_valid, cmt_reg_we, cmt_mispredict, flush;
	lc3b_opcode disp_opcode, cmt_opcode;
	lc3b_reg    disp_dest, cmt_dest;
	lc3b_word   wb_value, cmt_value;
	rob_tag     wb_tag, disp_tag;

	integer     seed = 32'h2016;
	lc3b_opcode ops [8] = '{op_br, op_add, op_and, op_not, op_ldr, op_lea, op_trap, op_stb};
	entry_t     rob_q [$];
	entry_t     ret_q [$];
	rob_tag     tail_m = '0;
	logic       timed_out = 1'b0;
	int         disp_pct, rdy_pct, misp_mode;
	logic       wb_en;
	int         errors = 0;
	int         passed = 0;
	int         failed = 0;
	int         dispatched = 0;
	int         retired = 0;
	int         flushes = 0;

	rob_top dut0 (.*);

	always #20 clk = ~clk;

	function automatic int pick(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Opcodes that write a destination register.
	function automatic logic writes_register(lc3b_opcode op);
		return op inside {op_add, op_and, op_not, op_ldr, op_lea, op_ldb};
	endfunction

	task automatic log_error(string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic drive_inputs(output int wb_idx);
		int open_idx [$];
		disp_valid   = pick(100) < disp_pct;
		disp_opcode  = ops[pick(8)];
		disp_dest    = lc3b_reg'(pick(8));
		disp_predict = pick(2) == 1;
		wb_valid     = 1'b0;
		wb_tag       = rob_tag'(pick(8));
		wb_value     = lc3b_word'(pick(65536));
		wb_taken     = pick(2) == 1;
		wb_idx       = -1;
		for (int i = 0; i < rob_q.size(); i++)
			if (!rob_q[i].done)
				open_idx.push_back(i);
		if (wb_en && open_idx.size() > 0 && pick(2) == 1)
		begin
			wb_idx   = open_idx[pick(open_idx.size())];
			wb_valid = 1'b1;
			wb_tag   = rob_q[wb_idx].tag;
			// Mode 0 resolves branches as predicted and mode 2 always against them.
			if (rob_q[wb_idx].op == op_br && misp_mode == 0)
				wb_taken = rob_q[wb_idx].predict;
			else if (rob_q[wb_idx].op == op_br && misp_mode == 2)
				wb_taken = !rob_q[wb_idx].predict;
		end
		else if (wb_en && rob_q.size() < ROB_DEPTH && pick(4) == 0)
		begin
			// A stray writeback to a free entry must be dropped.
			wb_valid = 1'b1;
			wb_tag   = tail_m + rob_tag'(pick(ROB_DEPTH - rob_q.size()));
		end
		cmt_ready = pick(100) < rdy_pct;
	endtask

	task automatic step();
		int     wb_idx;
		logic   exp_pop;
		logic   exp_flush;
		logic   d_fire;
		logic   c_fire;
		entry_t e;
		drive_inputs(wb_idx);
		@(negedge clk);
		exp_pop = rob_q.size() > 0 && rob_q[0].done && ret_q.size() < 2;
		exp_flush = exp_pop && rob_q[0].op == op_br && rob_q[0].taken != rob_q[0].predict;
		assert (flush == exp_flush)
			else log_error($sformatf("flush %0b, expected %0b", flush, exp_flush));
		assert (disp_ready == (rob_q.size() < ROB_DEPTH && !exp_flush))
			else log_error($sformatf("disp_ready %0b with %0d entries", disp_ready, rob_q.size()));
		assert (!disp_ready || disp_tag == tail_m)
			else log_error($sformatf("disp_tag %0d, expected %0d", disp_tag, tail_m));
		assert (cmt_valid == (ret_q.size() > 0))
			else log_error($sformatf("cmt_valid %0b with %0d queued", cmt_valid, ret_q.size()));
		if (cmt_valid && ret_q.size() > 0)
		begin
			e = ret_q[0];
			assert (cmt_opcode == e.op && cmt_dest == e.dest && cmt_value == e.value &&
				cmt_reg_we == writes_register(e.op) && cmt_mispredict == e.misp)
				else log_error($sformatf(
					"retired op %h r%0d %h we %0b mp %0b, expected %h r%0d %h tag %0d",
					cmt_opcode, cmt_dest, cmt_value, cmt_reg_we, cmt_mispredict,
					e.op, e.dest, e.value, e.tag));
		end
		d_fire = disp_valid && disp_ready;
		c_fire = cmt_valid && cmt_ready;
		@(posedge clk);
		#2;
		if (c_fire && ret_q.size() > 0)
		begin
			ret_q.delete(0);
			retired++;
		end
		if (wb_idx >= 0)
		begin
			rob_q[wb_idx].value = wb_value;
			rob_q[wb_idx].taken = wb_taken;
			rob_q[wb_idx].done  = 1'b1;
		end
		if (exp_pop)
		begin
			e = rob_q.pop_front();
			e.misp = exp_flush;
			ret_q.push_back(e);
		end
		// The branch itself stays queued and everything younger is dropped.
		if (exp_flush)
		begin
			rob_q.delete();
			tail_m = '0;
			flushes++;
		end
		else if (d_fire)
		begin
			e = '{tail_m, disp_opcode, disp_dest, disp_predict, '0, 1'b0, 1'b0, 1'b0};
			rob_q.push_back(e);
			tail_m++;
			dispatched++;
		end
	endtask

	task automatic run_phase(int cycles, int d_pct, logic wb_on, int r_pct, int misp);
		disp_pct = d_pct;
		wb_en = wb_on;
		rdy_pct = r_pct;
		misp_mode = misp;
		for (int i = 0; i < cycles && !timed_out; i++)
			step();
	endtask

	task automatic drain();
		int n;
		n = 0;
		run_phase(0, 0, 1'b1, 100, 0);
		while (!timed_out && rob_q.size() + ret_q.size() > 0 && n < 150)
		begin
			step();
			n++;
		end
		if (!timed_out && rob_q.size() + ret_q.size() > 0)
		begin
			$display("Timeout: the buffer did not drain within 150 cycles");
			timed_out = 1'b1;
		end
	endtask

	task automatic report_test(string name, int start_errors);
		if (errors == start_errors && !timed_out)
		begin
			$display("test %s: ok", name);
			passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - start_errors);
			failed++;
		end
	endtask

	initial
	begin
		int mark;
		int count_mark;
		rst_n = 1'b0;
		run_phase(0, 0, 1'b0, 0, 0);
		{disp_valid, disp_predict, wb_valid, wb_taken, cmt_ready} = '0;
		disp_opcode = op_br;
		disp_dest = '0;
		wb_tag = '0;
		wb_value = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		mark = errors;
		@(negedge clk);
		assert (disp_ready === 1'b1 && cmt_valid === 1'b0 && flush === 1'b0)
			else log_error("disp_ready, cmt_valid or flush wrong after reset");
		@(posedge clk);
		#2;
		report_test("after reset", mark);

		mark = errors;
		run_phase(300, 60, 1'b1, 80, 0);
		drain();
		report_test("in-order retirement", mark);

		mark = errors;
		count_mark = dispatched;
		run_phase(16, 100, 1'b0, 100, 0);
		assert (dispatched - count_mark == ROB_DEPTH)
			else log_error($sformatf("%0d dispatches accepted, expected 8", dispatched - count_mark));
		run_phase(0, 0, 1'b1, 100, 0);
		count_mark = 0;
		while (!timed_out && !disp_ready && count_mark < 50)
		begin
			step();
			count_mark++;
		end
		if (!timed_out && !disp_ready)
		begin
			$display("Timeout: disp_ready stayed low after writeback resumed");
			timed_out = 1'b1;
		end
		drain();
		report_test("capacity", mark);

		mark = errors;
		run_phase(400, 70, 1'b1, 20, 0);
		drain();
		report_test("retire back-pressure", mark);

		mark = errors;
		count_mark = flushes;
		run_phase(300, 60, 1'b1, 70, 2);
		drain();
		assert (timed_out || flushes > count_mark)
			else log_error("no mispredict flush was seen");
		report_test("mispredict flush", mark);

		mark = errors;
		run_phase(2000, 50, 1'b1, 60, 1);
		drain();
		report_test("random mix", mark);

		$display("%0d tests passed, %0d failed, %0d errors, %0d retired, %0d flushes",
			passed, failed, errors, retired, flushes);
		if (failed == 0 && errors == 0 && !timed_out)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== src.f ====
source/lc3b_isa_pkg.sv
source/rob_pkg.sv
source/rob_field_array.sv
source/rob_control.sv
source/rob_retire_queue.sv
source/rob_top.sv
bench/rob_tb.sv

// ==== Makefile ====
TOOL       = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = rob_tb
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ** PASS **

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
